// ==== design/dma_isa_pkg.sv ====
// Custom DMA instruction set; only CONF, SET-AL, SET-SR2 and SET-START exist, other SET codes do nothing.

package dma_isa_pkg;

  //////////////////////////////
  // Field widths
  //////////////////////////////

  localparam int unsigned XLEN          = 32;
  localparam int unsigned OPCODE_W      = 7;
  localparam int unsigned FUNC3_W       = 3;

  // CONF sub-fields, listed from the MSB down to the LSB.
  localparam int unsigned ND_EN_W       = 1;
  localparam int unsigned MAX_LOG_LEN_W = 3; // Per side, dst and src.
  localparam int unsigned REDUCE_LEN_W  = 1; // Per side, dst and src.
  localparam int unsigned DECOUPLE_W    = 1; // Per channel pair, r_w and r_aw.

  localparam int unsigned CONF_W = ND_EN_W + 2 * MAX_LOG_LEN_W + 2 * REDUCE_LEN_W +
                                   2 * DECOUPLE_W;

  //////////////////////////////
  // Field offsets
  //////////////////////////////

  localparam int unsigned OPCODE_OFF = 0;
  localparam int unsigned FUNC3_OFF  = 12;
  localparam int unsigned CONF_OFF   = 15;   // CONF spans bits 15 to 25.

  typedef logic [XLEN-1:0]     instr_t;
  typedef logic [XLEN-1:0]     operand_t;
  typedef logic [OPCODE_W-1:0] opcode_t;
  typedef logic [FUNC3_W-1:0]  func3_t;
  typedef logic [CONF_W-1:0]   conf_t;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  localparam opcode_t CONF_OPCODE     = 7'h5B;
  localparam opcode_t SET_OPCODE      = 7'h7B;

  localparam func3_t  SET_AL_FUNC3    = 3'd0; // rs2 dst addr, rs1 src addr, rs0 length.
  localparam func3_t  SET_SR2_FUNC3   = 3'd1; // rs2 dst stride, rs1 src stride, rs0 reps.
  localparam func3_t  SET_START_FUNC3 = 3'd3;

  // One issue beat from the core; the operands are meaningful only with rs_valid.
  typedef struct packed {
    instr_t   instr;
    operand_t rs0;
    operand_t rs1;
    operand_t rs2;
    logic     rs_valid;
  } xif_issue_req_t;

endpackage

// ==== design/dma_fe_reg_pkg.sv ====
// DMA frontend register map, 32-bit low words only; the third dimension is not mapped here.

package dma_fe_reg_pkg;

  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [STRB_W-1:0] strb_t;

  //////////////////////////////
  // Register bus
  //////////////////////////////

  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t wdata;
    strb_t wstrb;
    logic  valid;
  } fe_reg_req_t;

  typedef struct packed {
    data_t rdata;
    logic  ready;
    logic  error;
  } fe_reg_rsp_t;

  //////////////////////////////
  // Register offsets
  //////////////////////////////

  localparam addr_t CONF_OFFSET         = 32'h0000_0000;
  localparam addr_t NEXT_ID_OFFSET      = 32'h0000_0044;
  localparam addr_t DONE_ID_OFFSET      = 32'h0000_0084;
  localparam addr_t DST_ADDR_OFFSET     = 32'h0000_00D0;
  localparam addr_t SRC_ADDR_OFFSET     = 32'h0000_00D8;
  localparam addr_t LENGTH_OFFSET       = 32'h0000_00E0;
  localparam addr_t DST_STRIDE_2_OFFSET = 32'h0000_00E8;
  localparam addr_t SRC_STRIDE_2_OFFSET = 32'h0000_00F0;
  localparam addr_t REPS_2_OFFSET       = 32'h0000_00F8;

  //////////////////////////////
  // Staged registers
  //////////////////////////////

  // Lower index means higher write priority.
  localparam int unsigned CONF_IDX         = 0;
  localparam int unsigned DST_ADDR_IDX     = 1;
  localparam int unsigned SRC_ADDR_IDX     = 2;
  localparam int unsigned LENGTH_IDX       = 3;
  localparam int unsigned DST_STRIDE_2_IDX = 4;
  localparam int unsigned SRC_STRIDE_2_IDX = 5;
  localparam int unsigned REPS_2_IDX       = 6;
  localparam int unsigned N_CFG_REG        = 7;

  typedef data_t [N_CFG_REG-1:0]         cfg_bank_t;
  typedef logic  [N_CFG_REG-1:0]         cfg_mask_t;
  typedef logic  [$clog2(N_CFG_REG)-1:0] cfg_idx_t;

  // Frontend offset of each staged register, indexed by its staged index.
  localparam addr_t [N_CFG_REG-1:0] CFG_OFFSET = {
    REPS_2_OFFSET, SRC_STRIDE_2_OFFSET, DST_STRIDE_2_OFFSET, LENGTH_OFFSET,
    SRC_ADDR_OFFSET, DST_ADDR_OFFSET, CONF_OFFSET
  };

endpackage

// ==== design/xif_issue_decoder.sv ====
// Unknown opcodes are never answered; SET with rs_valid low, or an unused func3, is accepted and ignored.

`timescale 1ns/1ps

module xif_issue_decoder (
  input  logic                        clk_dc_g,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        issue_valid_i,
  input  dma_isa_pkg::xif_issue_req_t issue_req_i,
  output logic                        issue_ready_o,
  output logic                        issue_accept_o,
  input  dma_fe_reg_pkg::cfg_mask_t   pend_clr_i,
  output dma_fe_reg_pkg::cfg_bank_t   cfg_o,
  output dma_fe_reg_pkg::cfg_mask_t   pend_o,
  output logic                        start_req_o
);

  dma_isa_pkg::opcode_t      opcode;
  dma_isa_pkg::func3_t       func3;
  dma_isa_pkg::conf_t        conf;
  logic                      is_conf;
  logic                      is_set;
  logic                      issue_fire;
  dma_fe_reg_pkg::cfg_bank_t wr_data;  // New values for the staged registers.
  dma_fe_reg_pkg::cfg_mask_t wr_mask;  // Staged registers loaded this cycle.
  dma_fe_reg_pkg::cfg_bank_t cfg_q;
  dma_fe_reg_pkg::cfg_mask_t pend_q;

  //////////////////////////////
  // Field extraction
  //////////////////////////////

  assign opcode = issue_req_i.instr[dma_isa_pkg::OPCODE_OFF +: dma_isa_pkg::OPCODE_W];
  assign func3  = issue_req_i.instr[dma_isa_pkg::FUNC3_OFF +: dma_isa_pkg::FUNC3_W];
  assign conf   = issue_req_i.instr[dma_isa_pkg::CONF_OFF +: dma_isa_pkg::CONF_W];

  assign is_conf = (opcode == dma_isa_pkg::CONF_OPCODE);
  assign is_set  = (opcode == dma_isa_pkg::SET_OPCODE);

  assign issue_ready_o  = issue_valid_i & (is_conf | is_set);
  assign issue_accept_o = issue_valid_i & (is_conf | is_set);
  assign issue_fire     = issue_ready_o & issue_accept_o;

  assign start_req_o = issue_fire & is_set & (func3 == dma_isa_pkg::SET_START_FUNC3);

  //////////////////////////////
  // Staged register loads
  //////////////////////////////

  always_comb begin
    wr_data = cfg_q;
    wr_mask = '0;
    if (issue_fire && is_conf) begin
      wr_data[dma_fe_reg_pkg::CONF_IDX] = dma_fe_reg_pkg::data_t'(conf); // Zero-extended.
      wr_mask[dma_fe_reg_pkg::CONF_IDX] = 1'b1;
    end else if (issue_fire && is_set && issue_req_i.rs_valid) begin
      case (func3)
        dma_isa_pkg::SET_AL_FUNC3: begin
          wr_data[dma_fe_reg_pkg::DST_ADDR_IDX] = issue_req_i.rs2;
          wr_data[dma_fe_reg_pkg::SRC_ADDR_IDX] = issue_req_i.rs1;
          wr_data[dma_fe_reg_pkg::LENGTH_IDX]   = issue_req_i.rs0;
          wr_mask[dma_fe_reg_pkg::DST_ADDR_IDX] = 1'b1;
          wr_mask[dma_fe_reg_pkg::SRC_ADDR_IDX] = 1'b1;
          wr_mask[dma_fe_reg_pkg::LENGTH_IDX]   = 1'b1;
        end
        dma_isa_pkg::SET_SR2_FUNC3: begin
          wr_data[dma_fe_reg_pkg::DST_STRIDE_2_IDX] = issue_req_i.rs2;
          wr_data[dma_fe_reg_pkg::SRC_STRIDE_2_IDX] = issue_req_i.rs1;
          wr_data[dma_fe_reg_pkg::REPS_2_IDX]       = issue_req_i.rs0;
          wr_mask[dma_fe_reg_pkg::DST_STRIDE_2_IDX] = 1'b1;
          wr_mask[dma_fe_reg_pkg::SRC_STRIDE_2_IDX] = 1'b1;
          wr_mask[dma_fe_reg_pkg::REPS_2_IDX]       = 1'b1;
        end
        default: begin
          wr_mask = '0; // Start and unused codes touch no staged register.
        end
      endcase
    end
  end

  always_ff @(posedge clk_dc_g or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      pend_q <= '0;
    end else if (clear_i) begin
      cfg_q  <= '0;
      pend_q <= '0;
    end else begin
      for (int i = 0; i < dma_fe_reg_pkg::N_CFG_REG; i++) begin
        if (wr_mask[i]) cfg_q[i] <= wr_data[i];
      end
      pend_q <= wr_mask | (pend_q & ~pend_clr_i); // A fresh load wins over a clear.
    end
  end

  assign cfg_o  = cfg_q;
  assign pend_o = pend_q;

  a_accept_needs_ready : assert property (@(posedge clk_dc_g) disable iff (!rst_ni)
    issue_accept_o |-> issue_ready_o)
    else $error("Issue accepted without ready.");

endmodule

// ==== design/fe_cfg_writer.sv ====
// The tracker wins the bus unless a stalled config write is still waiting for ready.

`timescale 1ns/1ps

module fe_cfg_writer (
  input  logic                        clk_dc_g,
  input  logic                        rst_ni,
  input  dma_fe_reg_pkg::cfg_bank_t   cfg_i,
  input  dma_fe_reg_pkg::cfg_mask_t   pend_i,
  output dma_fe_reg_pkg::cfg_mask_t   pend_clr_o,
  input  dma_fe_reg_pkg::fe_reg_req_t trk_req_i,
  output dma_fe_reg_pkg::fe_reg_rsp_t trk_rsp_o,
  input  logic                        trk_id_err_i,
  output dma_fe_reg_pkg::fe_reg_req_t fe_req_o,
  input  dma_fe_reg_pkg::fe_reg_rsp_t fe_rsp_i,
  output logic                        error_o
);

  dma_fe_reg_pkg::cfg_idx_t    sel_idx;     // Lowest pending index.
  logic                        sel_vld;
  dma_fe_reg_pkg::cfg_idx_t    cfg_idx;
  logic                        cfg_hold;    // Keep the stalled write on the bus.
  logic                        trk_own;
  logic                        cfg_done;
  dma_fe_reg_pkg::fe_reg_req_t cfg_req;
  logic                        cfg_stall_q;
  logic                        bus_stall_q;
  dma_fe_reg_pkg::cfg_idx_t    hold_idx_q;
  dma_fe_reg_pkg::fe_reg_req_t last_req_q;

  always_comb begin
    sel_idx = '0;
    sel_vld = 1'b0;
    for (int i = dma_fe_reg_pkg::N_CFG_REG - 1; i >= 0; i--) begin
      if (pend_i[i]) begin
        sel_idx = dma_fe_reg_pkg::cfg_idx_t'(i);
        sel_vld = 1'b1;
      end
    end
  end

  // A clear drops every pending bit, which also withdraws a held write.
  assign cfg_hold = cfg_stall_q & sel_vld;
  assign cfg_idx  = cfg_hold ? hold_idx_q : sel_idx;
  assign trk_own  = trk_req_i.valid & ~cfg_hold;

  always_comb begin
    if (cfg_hold) begin
      cfg_req = last_req_q;
    end else begin
      cfg_req.addr  = dma_fe_reg_pkg::CFG_OFFSET[sel_idx];
      cfg_req.write = 1'b1;
      cfg_req.wdata = cfg_i[sel_idx];
      cfg_req.wstrb = '1;
      cfg_req.valid = sel_vld;
    end
  end

  assign fe_req_o  = trk_own ? trk_req_i : cfg_req;
  assign trk_rsp_o = trk_own ? fe_rsp_i : dma_fe_reg_pkg::fe_reg_rsp_t'('0);

  assign cfg_done   = ~trk_own & sel_vld & fe_rsp_i.ready;
  assign pend_clr_o = (cfg_done && !fe_rsp_i.error) ?
                      (dma_fe_reg_pkg::cfg_mask_t'(1) << cfg_idx) : '0;

  assign error_o = (fe_req_o.valid & fe_rsp_i.ready & fe_rsp_i.error) | trk_id_err_i;

  always_ff @(posedge clk_dc_g or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_stall_q <= 1'b0;
      bus_stall_q <= 1'b0;
    end else begin
      cfg_stall_q <= ~trk_own & sel_vld & ~fe_rsp_i.ready;
      bus_stall_q <= fe_req_o.valid & ~fe_rsp_i.ready;
    end
  end

  always_ff @(posedge clk_dc_g) begin
    hold_idx_q <= cfg_idx;
    last_req_q <= fe_req_o;
  end

  // The owner may withdraw on clear, but must not change a request that stays valid.
  a_req_stable : assert property (@(posedge clk_dc_g) disable iff (!rst_ni)
    (bus_stall_q && fe_req_o.valid) |-> (fe_req_o == last_req_q))
    else $error("Bus request changed while waiting for ready.");

endmodule

// ==== design/dma_transfer_tracker.sv ====
// One transfer at a time; the ID register holds one after reset and a NEXT_ID of zero aborts.

`timescale 1ns/1ps

module dma_transfer_tracker (
  input  logic                        clk_dc_g,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        start_req_i,
  output dma_fe_reg_pkg::fe_reg_req_t trk_req_o,
  input  dma_fe_reg_pkg::fe_reg_rsp_t trk_rsp_i,
  output logic                        trk_id_err_o,
  output logic                        start_o,
  output logic                        busy_o,
  output logic                        done_o
);

  typedef enum logic [1:0] {
    IDLE,
    START,
    BUSY,
    DONE
  } trk_state_e;

  trk_state_e            state_q;
  trk_state_e            state_d;
  dma_fe_reg_pkg::data_t id_q;
  dma_fe_reg_pkg::data_t id_d;

  function automatic dma_fe_reg_pkg::fe_reg_req_t rd_req(input dma_fe_reg_pkg::addr_t addr);
    dma_fe_reg_pkg::fe_reg_req_t req;
    req       = '0;
    req.addr  = addr;
    req.valid = 1'b1;
    return req;
  endfunction

  //////////////////////////////
  // Next state and outputs
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    id_d         = id_q;
    trk_req_o    = '0;
    trk_id_err_o = 1'b0;
    start_o      = 1'b0;
    busy_o       = 1'b0;
    done_o       = 1'b0;
    case (state_q)
      IDLE: begin
        if (start_req_i) state_d = START;
      end
      START: begin
        start_o   = 1'b1;
        trk_req_o = rd_req(dma_fe_reg_pkg::NEXT_ID_OFFSET); // Reading NEXT_ID launches.
        if (trk_rsp_i.ready) begin
          if (trk_rsp_i.error) begin
            state_d = IDLE;
          end else if (trk_rsp_i.rdata == '0) begin
            trk_id_err_o = 1'b1; // The frontend refused the transfer.
            state_d      = IDLE;
          end else begin
            id_d    = trk_rsp_i.rdata;
            state_d = BUSY;
          end
        end
      end
      BUSY: begin
        busy_o    = 1'b1;
        trk_req_o = rd_req(dma_fe_reg_pkg::DONE_ID_OFFSET); // Polled until it matches.
        if (trk_rsp_i.ready) begin
          if (trk_rsp_i.error) begin
            state_d = IDLE;
          end else if (trk_rsp_i.rdata == id_q) begin
            state_d = DONE;
          end
        end
      end
      DONE: begin
        done_o  = 1'b1;
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_dc_g or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      id_q    <= dma_fe_reg_pkg::data_t'(1);
    end else if (clear_i) begin
      state_q <= IDLE;
      id_q    <= dma_fe_reg_pkg::data_t'(1);
    end else begin
      state_q <= state_d;
      id_q    <= id_d;
    end
  end

  a_status_onehot : assert property (@(posedge clk_dc_g) disable iff (!rst_ni)
    $onehot0({start_o, busy_o, done_o}))
    else $error("More than one transfer status is active.");

endmodule

// ==== design/xif_dma_ctrl_top.sv ====
// Single clock clk_dc_g; issue answers are combinational and config writes stall during a transfer.

`timescale 1ns/1ps

module xif_dma_ctrl_top (
  input  logic                        clk_dc_g,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        issue_valid_i,
  input  dma_isa_pkg::xif_issue_req_t issue_req_i,
  output logic                        issue_ready_o,
  output logic                        issue_accept_o,
  output dma_fe_reg_pkg::fe_reg_req_t fe_req_o,
  input  dma_fe_reg_pkg::fe_reg_rsp_t fe_rsp_i,
  output logic                        start_o,
  output logic                        busy_o,
  output logic                        done_o,
  output logic                        error_o
);

  dma_fe_reg_pkg::cfg_bank_t   cfg;        // Staged register values.
  dma_fe_reg_pkg::cfg_mask_t   pend;       // Values not yet written to the frontend.
  dma_fe_reg_pkg::cfg_mask_t   pend_clr;   // Writes that completed cleanly this cycle.
  logic                        start_req;  // Start instruction accepted.
  dma_fe_reg_pkg::fe_reg_req_t trk_req;
  dma_fe_reg_pkg::fe_reg_rsp_t trk_rsp;
  logic                        trk_id_err; // NEXT_ID read back as zero.

  xif_issue_decoder u_decoder (
    .clk_dc_g       (clk_dc_g),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .issue_valid_i  (issue_valid_i),
    .issue_req_i    (issue_req_i),
    .issue_ready_o  (issue_ready_o),
    .issue_accept_o (issue_accept_o),
    .pend_clr_i     (pend_clr),
    .cfg_o          (cfg),
    .pend_o         (pend),
    .start_req_o    (start_req)
  );

  fe_cfg_writer u_writer (
    .clk_dc_g     (clk_dc_g),
    .rst_ni       (rst_ni),
    .cfg_i        (cfg),
    .pend_i       (pend),
    .pend_clr_o   (pend_clr),
    .trk_req_i    (trk_req),
    .trk_rsp_o    (trk_rsp),
    .trk_id_err_i (trk_id_err),
    .fe_req_o     (fe_req_o),
    .fe_rsp_i     (fe_rsp_i),
    .error_o      (error_o)
  );

  dma_transfer_tracker u_tracker (
    .clk_dc_g     (clk_dc_g),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .start_req_i  (start_req),
    .trk_req_o    (trk_req),
    .trk_rsp_i    (trk_rsp),
    .trk_id_err_o (trk_id_err),
    .start_o      (start_o),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

endmodule

// ==== dv/fe_reg_model.sv ====
// Behavioral DMA frontend; ready is chosen on the falling edge, accesses complete on the rising edge.

`timescale 1ns/1ps

module fe_reg_model (
  input  logic                        clk_dc_g,
  input  logic                        rst_ni,
  input  dma_fe_reg_pkg::fe_reg_req_t req_i,
  output dma_fe_reg_pkg::fe_reg_rsp_t rsp_o
);

  dma_fe_reg_pkg::fe_reg_req_t wr_log[$];          // Error-free writes in completion order.
  dma_fe_reg_pkg::data_t       next_id      = 1;    // Answer to NEXT_ID reads.
  dma_fe_reg_pkg::data_t       launch_id    = 0;    // ID handed out by the last NEXT_ID read.
  dma_fe_reg_pkg::data_t       done_id_q    = 0;    // ID of the last finished transfer.
  dma_fe_reg_pkg::data_t       last_done_rd = 0;
  int unsigned                 err_target   = 0;    // Write access number that gets an error.
  int unsigned                 n_wr_acc     = 0;
  int unsigned                 polls_left   = 0;
  int unsigned                 wait_cnt     = 0;
  logic                        hold_ready   = 1'b0; // Stalls the bus while set.
  dma_fe_reg_pkg::fe_reg_rsp_t rsp_q        = '0;

  assign rsp_o = rsp_q;

  function automatic dma_fe_reg_pkg::data_t read_data(input dma_fe_reg_pkg::addr_t addr);
    if (addr == dma_fe_reg_pkg::NEXT_ID_OFFSET) begin
      return next_id;
    end
    if (addr == dma_fe_reg_pkg::DONE_ID_OFFSET) begin
      return (polls_left == 0) ? launch_id : done_id_q; // The old ID until enough polls.
    end
    return '0;
  endfunction

  //////////////////////////////
  // Response timing
  //////////////////////////////

  always @(negedge clk_dc_g) begin
    if (rsp_q.ready) wait_cnt = $urandom_range(3, 0); // A fresh request starts its own delay.
    if (rst_ni && req_i.valid && !hold_ready && wait_cnt == 0) begin
      rsp_q.ready <= 1'b1;
      rsp_q.error <= req_i.write && (n_wr_acc + 1 == err_target);
      rsp_q.rdata <= read_data(req_i.addr);
    end else begin
      rsp_q <= '0;
      if (rst_ni && req_i.valid && !hold_ready) wait_cnt--;
    end
  end

  //////////////////////////////
  // Completions
  //////////////////////////////

  always @(posedge clk_dc_g) begin
    if (rst_ni && req_i.valid && rsp_q.ready) begin
      if (req_i.write) begin
        n_wr_acc++;
        if (!rsp_q.error) wr_log.push_back(req_i);
      end else if (req_i.addr == dma_fe_reg_pkg::NEXT_ID_OFFSET) begin
        launch_id  = next_id;
        polls_left = $urandom_range(4, 1); // The transfer needs a few polls to finish.
      end else if (req_i.addr == dma_fe_reg_pkg::DONE_ID_OFFSET) begin
        last_done_rd = rsp_q.rdata;
        if (polls_left == 0) done_id_q = launch_id;
        else polls_left--;
      end
    end
  end

endmodule

// ==== dv/tb_xif_dma_ctrl.sv ====
// Random frontend latency; stimulus changes on the falling edge and DUT outputs are sampled on the rising edge.

`timescale 1ns/1ps

module tb_xif_dma_ctrl;

  localparam int unsigned TIMEOUT = 2000;
  localparam int W_DRAIN = 0;
  localparam int W_BUS   = 1;
  localparam int W_DONE  = 2;
  localparam int W_ERR   = 3;
  localparam int W_IDLE  = 4;

  typedef dma_fe_reg_pkg::fe_reg_req_t wr_q_t[$];

  logic                        clk_dc_g;
  logic                        rst_ni;
  logic                        clear_i;
  logic                        issue_valid_i;
  dma_isa_pkg::xif_issue_req_t issue_req_i;
  logic                        issue_ready_o;
  logic                        issue_accept_o;
  dma_fe_reg_pkg::fe_reg_req_t fe_req;
  dma_fe_reg_pkg::fe_reg_rsp_t fe_rsp;
  logic                        start_o;
  logic                        busy_o;
  logic                        done_o;
  logic                        error_o;
  wr_q_t                       exp_q;       // Writes still expected on the bus, in order.
  string                       test_name;
  int unsigned                 n_checks;
  int unsigned                 n_errors;
  int unsigned                 n_start;
  int unsigned                 n_busy;
  int unsigned                 n_done;
  int unsigned                 n_err;
  logic                        prev_start;
  logic                        prev_busy;

  initial clk_dc_g = 1'b0;
  always #4 clk_dc_g = ~clk_dc_g;

  xif_dma_ctrl_top UUT (
    .clk_dc_g       (clk_dc_g),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .issue_valid_i  (issue_valid_i),
    .issue_req_i    (issue_req_i),
    .issue_ready_o  (issue_ready_o),
    .issue_accept_o (issue_accept_o),
    .fe_req_o       (fe_req),
    .fe_rsp_i       (fe_rsp),
    .start_o        (start_o),
    .busy_o         (busy_o),
    .done_o         (done_o),
    .error_o        (error_o)
  );

  fe_reg_model u_fe (
    .clk_dc_g (clk_dc_g),
    .rst_ni   (rst_ni),
    .req_i    (fe_req),
    .rsp_o    (fe_rsp)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic dma_fe_reg_pkg::fe_reg_req_t wr_req(input logic [31:0] addr,
                                                         input logic [31:0] data);
    dma_fe_reg_pkg::fe_reg_req_t req;
    req       = '0;
    req.addr  = addr;
    req.write = 1'b1;
    req.wdata = data;
    req.wstrb = 4'hF;                                        // Full word writes only.
    req.valid = 1'b1;
    return req;
  endfunction

  // Writes one accepted instruction causes; lower register index goes first.
  function automatic wr_q_t ref_writes(input dma_isa_pkg::xif_issue_req_t req);
    wr_q_t q;
    q = {};
    if (req.instr[6:0] == 7'h5B) begin
      q.push_back(wr_req(32'h00, {21'b0, req.instr[25:15]})); // The CONF field is zero-extended.
    end else if (req.instr[6:0] == 7'h7B && req.rs_valid && req.instr[14:12] == 3'd0) begin
      q.push_back(wr_req(32'hD0, req.rs2));
      q.push_back(wr_req(32'hD8, req.rs1));
      q.push_back(wr_req(32'hE0, req.rs0));
    end else if (req.instr[6:0] == 7'h7B && req.rs_valid && req.instr[14:12] == 3'd1) begin
      q.push_back(wr_req(32'hE8, req.rs2));
      q.push_back(wr_req(32'hF0, req.rs1));
      q.push_back(wr_req(32'hF8, req.rs0));
    end
    return q;
  endfunction

  function automatic dma_isa_pkg::instr_t make_instr(input dma_isa_pkg::opcode_t opcode,
                                                     input dma_isa_pkg::func3_t func3);
    dma_isa_pkg::instr_t instr;
    instr        = $urandom;
    instr[6:0]   = opcode;
    instr[14:12] = func3;
    return instr;
  endfunction

  //////////////////////////////
  // Checks and waits
  //////////////////////////////

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAIL %s %s: expected 0x%h, actual 0x%h", test_name, what, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  function automatic bit cond_met(input int cond);
    case (cond)
      W_DRAIN: return exp_q.size() == 0 && !fe_req.valid;
      W_BUS:   return fe_req.valid;
      W_DONE:  return done_o;
      W_ERR:   return error_o;
      default: return !start_o && !busy_o;
    endcase
  endfunction

  task automatic wait_until(input string what, input int cond);
    int unsigned cycles;
    cycles = 0;
    do begin
      @(posedge clk_dc_g);
      cycles++;
    end while (!cond_met(cond) && cycles < TIMEOUT);
    if (!cond_met(cond)) begin
      n_errors++;
      $display("ERROR: %s: no %s within %0d cycles", test_name, what, TIMEOUT);
      finish_run();
    end
  endtask

  task automatic issue_instr(input dma_isa_pkg::instr_t instr, input logic [31:0] rs0,
                             input logic [31:0] rs1, input logic [31:0] rs2,
                             input logic rs_valid, input logic known);
    dma_isa_pkg::xif_issue_req_t req;
    wr_q_t                       wr_exp;
    req.instr    = instr;
    req.rs0      = rs0;
    req.rs1      = rs1;
    req.rs2      = rs2;
    req.rs_valid = rs_valid;
    @(negedge clk_dc_g);
    issue_req_i   = req;
    issue_valid_i = 1'b1;
    @(posedge clk_dc_g);
    check_val("issue_ready_o", known, issue_ready_o);
    check_val("issue_accept_o", known, issue_accept_o);
    if (issue_accept_o) begin
      wr_exp = ref_writes(req);
      foreach (wr_exp[i]) exp_q.push_back(wr_exp[i]);
    end
    @(negedge clk_dc_g);
    issue_valid_i = 1'b0;
    issue_req_i   = '0;
  endtask

  // Counts status cycles and checks that start, busy and done come in order.
  always @(posedge clk_dc_g) begin
    if (rst_ni) begin
      if (start_o) n_start++;
      if (busy_o) begin
        n_busy++;
        if (!prev_start && !prev_busy) begin
          n_errors++;
          $display("ERROR: %s: busy_o rose without start_o before it", test_name);
        end
      end
      if (done_o) begin
        n_done++;
        if (!prev_busy) begin
          n_errors++;
          $display("ERROR: %s: done_o rose without busy_o before it", test_name);
        end
      end
      if (error_o) n_err++;
    end
    prev_start = start_o;
    prev_busy  = busy_o;
  end

  // Compares every logged frontend write with the next expected one.
  always @(negedge clk_dc_g) begin
    dma_fe_reg_pkg::fe_reg_req_t got_wr;
    dma_fe_reg_pkg::fe_reg_req_t exp_wr;
    while (u_fe.wr_log.size() > 0) begin
      got_wr = u_fe.wr_log.pop_front();
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("ERROR: %s: unexpected write of 0x%h to offset 0x%h", test_name,
                 got_wr.wdata, got_wr.addr);
      end else begin
        exp_wr = exp_q.pop_front();
        check_val("write offset", exp_wr.addr, got_wr.addr);
        check_val("write data", exp_wr.wdata, got_wr.wdata);
        check_val("write strobes", exp_wr.wstrb, got_wr.wstrb);
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int unsigned seed;
    int unsigned s0;
    int unsigned b0;
    int unsigned d0;
    int unsigned e0;
    int unsigned wa0;
    logic [31:0] id;
    seed = 32'hcf94;
    void'($urandom(seed));
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_req_i   = '0;
    test_name     = "reset";
    n_checks      = 0;
    n_errors      = 0;
    n_start       = 0;
    n_busy        = 0;
    n_done        = 0;
    n_err         = 0;
    prev_start    = 1'b0;
    prev_busy     = 1'b0;
    repeat (16) @(negedge clk_dc_g);
    rst_ni = 1'b1;

    test_name = "conf";
    issue_instr(make_instr(dma_isa_pkg::CONF_OPCODE, 3'($urandom)), $urandom, $urandom,
                $urandom, 1'b1, 1'b1);
    wait_until("end of config writes", W_DRAIN);

    test_name = "al_sr2";
    issue_instr(make_instr(dma_isa_pkg::SET_OPCODE, dma_isa_pkg::SET_AL_FUNC3), $urandom,
                $urandom, $urandom, 1'b1, 1'b1);
    issue_instr(make_instr(dma_isa_pkg::SET_OPCODE, dma_isa_pkg::SET_SR2_FUNC3), $urandom,
                $urandom, $urandom, 1'b1, 1'b1);
    wait_until("end of config writes", W_DRAIN);

    test_name = "start";
    id = $urandom_range(32'hFFFF, 1);
    u_fe.next_id = id;
    s0 = n_start;
    b0 = n_busy;
    d0 = n_done;
    e0 = n_err;
    issue_instr(make_instr(dma_isa_pkg::SET_OPCODE, dma_isa_pkg::SET_START_FUNC3), $urandom,
                $urandom, $urandom, 1'b1, 1'b1);
    wait_until("done_o", W_DONE);
    repeat (2) @(negedge clk_dc_g);            // One more cycle shows whether done_o lingers.
    check_val("start_o seen", 1, n_start > s0);
    check_val("busy_o seen", 1, n_busy > b0);
    check_val("done_o cycles", d0 + 1, n_done);
    check_val("error_o cycles", e0, n_err);
    check_val("DONE_ID read", id, u_fe.last_done_rd);

    test_name = "zero_id";
    u_fe.next_id = 0;
    b0 = n_busy;
    d0 = n_done;
    e0 = n_err;
    issue_instr(make_instr(dma_isa_pkg::SET_OPCODE, dma_isa_pkg::SET_START_FUNC3), $urandom,
                $urandom, $urandom, 1'b1, 1'b1);
    wait_until("error_o", W_ERR);
    wait_until("tracker idle", W_IDLE);
    repeat (2) @(negedge clk_dc_g);
    check_val("busy_o cycles", b0, n_busy);
    check_val("done_o cycles", d0, n_done);
    check_val("error_o cycles", e0 + 1, n_err);

    test_name = "write_error";
    wa0 = u_fe.n_wr_acc;
    u_fe.err_target = wa0 + 1;                 // The next write gets an error response.
    e0 = n_err;
    issue_instr(make_instr(dma_isa_pkg::CONF_OPCODE, 3'($urandom)), $urandom, $urandom,
                $urandom, 1'b1, 1'b1);
    wait_until("end of config writes", W_DRAIN);
    @(negedge clk_dc_g);
    check_val("error_o cycles", e0 + 1, n_err);
    check_val("write accesses", wa0 + 2, u_fe.n_wr_acc);

    test_name = "unknown_op";
    issue_instr(make_instr(7'h33, 3'($urandom)), $urandom, $urandom, $urandom, 1'b1, 1'b0);

    test_name = "clear";
    u_fe.hold_ready = 1'b1;
    wa0 = u_fe.n_wr_acc;
    issue_instr(make_instr(dma_isa_pkg::SET_OPCODE, dma_isa_pkg::SET_AL_FUNC3), $urandom,
                $urandom, $urandom, 1'b1, 1'b1);
    wait_until("config write on the bus", W_BUS);
    @(negedge clk_dc_g);
    clear_i = 1'b1;
    exp_q.delete();                            // Clear drops every pending write.
    @(negedge clk_dc_g);
    clear_i         = 1'b0;
    u_fe.hold_ready = 1'b0;
    for (int i = 0; i < 20; i++) begin
      @(posedge clk_dc_g);
      if (fe_req.valid) begin
        n_errors++;
        $display("ERROR: %s: bus request still issued after clear_i", test_name);
      end
    end
    @(negedge clk_dc_g);
    check_val("write accesses", wa0, u_fe.n_wr_acc);
    finish_run();
  end

endmodule

// ==== project.f ====
design/dma_isa_pkg.sv
design/dma_fe_reg_pkg.sv
design/xif_issue_decoder.sv
design/fe_cfg_writer.sv
design/dma_transfer_tracker.sv
design/xif_dma_ctrl_top.sv
dv/fe_reg_model.sv
dv/tb_xif_dma_ctrl.sv
